/* src/ooo_pkg.sv */
package ooo_pkg;

	// ==========================================================================
	// core sizes
	// ==========================================================================

	localparam int word_w = 32;
	localparam int num_regs = 16;
	localparam int rob_entries = 8;

	typedef logic [3:0] reg_idx_t;
	typedef logic [2:0] tag_t;

	// free-entry count of the reorder buffer, one bit wider than a tag
	// so that a completely empty buffer can be reported
	typedef logic [$clog2(rob_entries):0] rob_cnt_t;

	// latencies are 1, 1, 2 and 4 cycles in this order
	typedef enum logic [1:0] {OP_ADD, OP_XOR, OP_SHL, OP_MUL} op_e;

	// ==========================================================================
	// transfer records between the blocks
	// ==========================================================================

	// one instruction slot of an incoming bundle
	typedef struct packed {
		logic valid;
		op_e op;
		reg_idx_t rd;
		reg_idx_t rs;
		logic [15:0] imm;
	} inst_t;

	// an instruction on its way from dispatch into a lane queue
	typedef struct packed {
		logic valid;
		op_e op;
		tag_t tag;
		logic [word_w-1:0] operand;
		logic [word_w-1:0] imm;
	} issue_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		logic [word_w-1:0] value;
	} result_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		reg_idx_t rd;
		logic [word_w-1:0] value;
	} commit_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		reg_idx_t rd;
	} alloc_t;

endpackage

/* src/dispatch_unit.sv */
`timescale 1ns/1ps

module dispatch_unit #(
	parameter int NUM_LANES = 3,
	parameter int LANE_DEPTH = 2
) (
	input logic clk,
	input logic rst,
	input logic flush,
	input ooo_pkg::inst_t [1:0] in_slot,
	input logic [ooo_pkg::num_regs-1:0] reg_ready,
	input logic [1:0][ooo_pkg::word_w-1:0] rd_value,
	input ooo_pkg::tag_t [1:0] next_tag,
	input ooo_pkg::rob_cnt_t rob_free,
	input logic [NUM_LANES-1:0] credit_return,
	output logic in_ready,
	output ooo_pkg::reg_idx_t [1:0] rd_addr,
	output ooo_pkg::issue_t [NUM_LANES-1:0] issue,
	output ooo_pkg::alloc_t [1:0] alloc
);

	localparam int CRED_W = $clog2(LANE_DEPTH + 1);

	logic [CRED_W-1:0] credit [NUM_LANES];
	logic [NUM_LANES-1:0] grant0;
	logic [NUM_LANES-1:0] grant1;
	logic slot0_v;
	logic slot1_v;
	logic src_ok0;
	logic src_ok1;
	logic hazard;
	logic lane_ok;
	logic take;
	logic live;
	ooo_pkg::rob_cnt_t need;

	// build the lane record, the immediate is sign-extended here
	function automatic ooo_pkg::issue_t make_issue(ooo_pkg::inst_t s, ooo_pkg::tag_t t,
			logic [ooo_pkg::word_w-1:0] operand);
		ooo_pkg::issue_t i;
		i.valid = 1'b1;
		i.op = s.op;
		i.tag = t;
		i.operand = operand;
		i.imm = {{(ooo_pkg::word_w - 16){s.imm[15]}}, s.imm};
		return i;
	endfunction

	// ==========================================================================
	// acceptance condition
	// ==========================================================================

	// slot 1 only counts when slot 0 is present
	assign slot0_v = in_slot[0].valid;
	assign slot1_v = in_slot[0].valid && in_slot[1].valid;

	// both sources are read from the register file with commit bypass
	assign rd_addr[0] = in_slot[0].rs;
	assign rd_addr[1] = in_slot[1].rs;

	// slot 1 cannot see slot 0's result, so that pair is refused as a whole
	assign hazard = slot1_v && in_slot[0].rd != '0 && in_slot[1].rs == in_slot[0].rd;
	assign src_ok0 = reg_ready[in_slot[0].rs];
	assign src_ok1 = !slot1_v || (reg_ready[in_slot[1].rs] && !hazard);
	assign need = ooo_pkg::rob_cnt_t'(slot0_v) + ooo_pkg::rob_cnt_t'(slot1_v);

	// first lane with a credit takes slot 0, the next one takes slot 1
	always_comb begin
		grant0 = '0;
		grant1 = '0;
		for (int l = 0; l < NUM_LANES; l++) begin
			if (credit[l] != '0) begin
				if (grant0 == '0)
					grant0[l] = 1'b1;
				else if (grant1 == '0)
					grant1[l] = 1'b1;
			end
		end
	end

	assign lane_ok = grant0 != '0 && (!slot1_v || grant1 != '0);
	assign in_ready = live && !flush
		&& (!slot0_v || (src_ok0 && src_ok1 && rob_free >= need && lane_ok));
	assign take = in_ready && slot0_v;

	// ==========================================================================
	// issue and allocation
	// ==========================================================================

	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			issue[l] = '0;
			if (take && grant0[l])
				issue[l] = make_issue(in_slot[0], next_tag[0], rd_value[0]);
			else if (take && slot1_v && grant1[l])
				issue[l] = make_issue(in_slot[1], next_tag[1], rd_value[1]);
		end
	end

	// every accepted slot takes a reorder-buffer entry, even with rd zero
	always_comb begin
		alloc[0].valid = take;
		alloc[0].tag = next_tag[0];
		alloc[0].rd = in_slot[0].rd;
		alloc[1].valid = take && slot1_v;
		alloc[1].tag = next_tag[1];
		alloc[1].rd = in_slot[1].rd;
	end

	// holds in_ready low until the first cycle after reset
	always_ff @(posedge clk) begin
		if (rst)
			live <= 1'b0;
		else
			live <= 1'b1;
	end

	// a flush empties every lane, so all credits come back at once
	always_ff @(posedge clk) begin
		for (int l = 0; l < NUM_LANES; l++) begin
			if (rst || flush)
				credit[l] <= CRED_W'(LANE_DEPTH);
			else
				credit[l] <= credit[l] - CRED_W'(issue[l].valid) + CRED_W'(credit_return[l]);
		end
	end

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_credit_chk
		// an issue at zero credit would wrap the counter above the lane depth,
		// and so would a credit that the lane returns without holding an entry
		a_issue_credit: assert property (@(posedge clk) disable iff (rst)
			credit[l] <= CRED_W'(LANE_DEPTH));
	end

endmodule

/* src/exec_lane.sv */
`timescale 1ns/1ps

module exec_lane #(
	parameter int LANE_DEPTH = 2
) (
	input logic clk,
	input logic rst,
	input logic flush,
	input ooo_pkg::issue_t issue,
	output ooo_pkg::result_t result,
	output logic credit_return
);

	localparam int PTR_W = (LANE_DEPTH > 1) ? $clog2(LANE_DEPTH) : 1;
	localparam int CNT_W = $clog2(LANE_DEPTH + 1);

	typedef enum logic {ST_IDLE, ST_BUSY} state_e;

	state_e state;
	ooo_pkg::issue_t queue [LANE_DEPTH];
	ooo_pkg::issue_t head;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [1:0] lat_left;
	logic pop;
	logic res_valid;
	ooo_pkg::tag_t res_tag;
	logic [ooo_pkg::word_w-1:0] res_value;

	function automatic logic [2:0] op_latency(ooo_pkg::op_e op);
		case (op)
			ooo_pkg::OP_SHL: return 3'd2;
			ooo_pkg::OP_MUL: return 3'd4;
			default: return 3'd1;
		endcase
	endfunction

	function automatic logic [ooo_pkg::word_w-1:0] op_value(ooo_pkg::issue_t i);
		case (i.op)
			ooo_pkg::OP_ADD: return i.operand + i.imm;
			ooo_pkg::OP_XOR: return i.operand ^ i.imm;
			ooo_pkg::OP_SHL: return i.operand << i.imm[4:0];
			default: return i.operand * i.imm;
		endcase
	endfunction

	function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
		return (p == PTR_W'(LANE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// the head stays in the queue while it executes
	assign head = queue[rd_ptr];

	// single-cycle ops leave straight from idle, longer ones after the countdown
	assign pop = !flush && count != '0
		&& ((state == ST_IDLE && op_latency(head.op) == 3'd1)
		|| (state == ST_BUSY && lat_left == 2'd0));

	// the slot freed by a pop is handed back to dispatch at once
	assign credit_return = pop;

	always_comb begin
		result.valid = res_valid;
		result.tag = res_tag;
		result.value = res_value;
	end

	always_ff @(posedge clk) begin
		if (issue.valid)
			queue[wr_ptr] <= issue;
		if (pop) begin
			res_tag <= head.tag;
			res_value <= op_value(head);
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			state <= ST_IDLE;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			lat_left <= '0;
			res_valid <= 1'b0;
		end else begin
			res_valid <= pop;
			if (issue.valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CNT_W'(issue.valid) - CNT_W'(pop);
			// the countdown ends at zero on the cycle before the result shows
			if (state == ST_IDLE && count != '0 && op_latency(head.op) != 3'd1) begin
				state <= ST_BUSY;
				lat_left <= 2'(op_latency(head.op) - 3'd2);
			end else if (state == ST_BUSY) begin
				if (lat_left == 2'd0)
					state <= ST_IDLE;
				else
					lat_left <= lat_left - 2'd1;
			end
		end
	end

	// the credit loop with dispatch should keep a full queue from being written
	a_no_overflow: assert property (@(posedge clk) disable iff (rst || flush)
		issue.valid |-> count < CNT_W'(LANE_DEPTH));

endmodule

/* src/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer #(
	parameter int NUM_LANES = 3
) (
	input logic clk,
	input logic rst,
	input logic flush,
	input ooo_pkg::alloc_t [1:0] alloc,
	input ooo_pkg::result_t [NUM_LANES-1:0] result,
	output ooo_pkg::tag_t [1:0] next_tag,
	output ooo_pkg::rob_cnt_t rob_free,
	output ooo_pkg::commit_t [1:0] commit
);

	logic [ooo_pkg::rob_entries-1:0] ent_valid;
	logic [ooo_pkg::rob_entries-1:0] ent_done;
	ooo_pkg::reg_idx_t ent_rd [ooo_pkg::rob_entries];
	logic [ooo_pkg::word_w-1:0] ent_value [ooo_pkg::rob_entries];
	ooo_pkg::tag_t head;
	ooo_pkg::tag_t head1;
	ooo_pkg::tag_t tail;
	ooo_pkg::rob_cnt_t count;
	logic c0;
	logic c1;
	logic [1:0] n_alloc;
	logic [1:0] n_commit;

	// ==========================================================================
	// allocation side
	// ==========================================================================

	// tags are the buffer slots, handed out in order from the tail
	assign next_tag[0] = tail;
	assign next_tag[1] = tail + ooo_pkg::tag_t'(1);
	assign rob_free = ooo_pkg::rob_cnt_t'(ooo_pkg::rob_entries) - count;
	assign n_alloc = {1'b0, alloc[0].valid} + {1'b0, alloc[1].valid};

	// ==========================================================================
	// commit side
	// ==========================================================================

	assign head1 = head + ooo_pkg::tag_t'(1);

	// only a run of done entries starting at the head may leave, and a flush
	// throws the whole run away instead
	assign c0 = !flush && ent_valid[head] && ent_done[head];
	assign c1 = c0 && ent_valid[head1] && ent_done[head1];
	assign n_commit = {1'b0, c0} + {1'b0, c1};

	always_comb begin
		commit[0].valid = c0;
		commit[0].tag = head;
		commit[0].rd = ent_rd[head];
		commit[0].value = ent_value[head];
		commit[1].valid = c1;
		commit[1].tag = head1;
		commit[1].rd = ent_rd[head1];
		commit[1].value = ent_value[head1];
	end

	// destination and result values of each entry
	always_ff @(posedge clk) begin
		for (int k = 0; k < 2; k++) begin
			if (alloc[k].valid)
				ent_rd[alloc[k].tag] <= alloc[k].rd;
		end
		for (int l = 0; l < NUM_LANES; l++) begin
			if (result[l].valid)
				ent_value[result[l].tag] <= result[l].value;
		end
	end

	// allocation, completion and commit touch different entries, since the
	// free count keeps the tail away from the head
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			ent_valid <= '0;
			ent_done <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			for (int k = 0; k < 2; k++) begin
				if (alloc[k].valid) begin
					ent_valid[alloc[k].tag] <= 1'b1;
					ent_done[alloc[k].tag] <= 1'b0;
				end
			end
			for (int l = 0; l < NUM_LANES; l++) begin
				if (result[l].valid)
					ent_done[result[l].tag] <= 1'b1;
			end
			if (c0)
				ent_valid[head] <= 1'b0;
			if (c1)
				ent_valid[head1] <= 1'b0;
			head <= head + ooo_pkg::tag_t'(n_commit);
			tail <= tail + ooo_pkg::tag_t'(n_alloc);
			count <= count + ooo_pkg::rob_cnt_t'(n_alloc) - ooo_pkg::rob_cnt_t'(n_commit);
		end
	end

	for (genvar l = 0; l < NUM_LANES; l++) begin : g_result_chk
		// a lane may only complete work that dispatch placed in the buffer
		a_result_alloc: assert property (@(posedge clk) disable iff (rst || flush)
			result[l].valid |-> ent_valid[result[l].tag]);
	end

endmodule

/* src/reg_valid_tracker.sv */
`timescale 1ns/1ps

module reg_valid_tracker (
	input logic clk,
	input logic rst,
	input logic flush,
	input ooo_pkg::alloc_t [1:0] alloc,
	input ooo_pkg::commit_t [1:0] commit,
	output logic [ooo_pkg::num_regs-1:0] reg_ready
);

	logic [ooo_pkg::num_regs-1:0] valid_q;
	ooo_pkg::tag_t prod_q [ooo_pkg::num_regs];
	logic [ooo_pkg::num_regs-1:0] commit_hit;

	// ==========================================================================
	// commits that release a register
	// ==========================================================================

	// a commit only counts if it is still the newest producer of its rd,
	// an older writer that was overtaken leaves the register pending
	always_comb begin
		commit_hit = '0;
		for (int r = 1; r < ooo_pkg::num_regs; r++) begin
			for (int k = 0; k < 2; k++) begin
				if (commit[k].valid && commit[k].rd == ooo_pkg::reg_idx_t'(r)
						&& !valid_q[r] && prod_q[r] == commit[k].tag)
					commit_hit[r] = 1'b1;
			end
		end
	end

	// advanced vector, already counting this cycle's releases so that a
	// dependent instruction can read through the register file bypass
	always_comb begin
		reg_ready = valid_q | commit_hit;
		if (flush)
			reg_ready = '1;
		reg_ready[0] = 1'b1;
	end

	// ==========================================================================
	// valid bits and producer tags
	// ==========================================================================

	// producer tags are only looked at while the valid bit is clear
	always_ff @(posedge clk) begin
		for (int k = 0; k < 2; k++) begin
			if (!rst && !flush && alloc[k].valid && alloc[k].rd != '0)
				prod_q[alloc[k].rd] <= alloc[k].tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			valid_q <= '1;
		end else begin
			valid_q <= valid_q | commit_hit;
			// new producers come after the releases, and slot 1 after slot 0,
			// so the youngest writer of a register is what remains
			for (int k = 0; k < 2; k++) begin
				if (alloc[k].valid && alloc[k].rd != '0)
					valid_q[alloc[k].rd] <= 1'b0;
			end
		end
	end

	// register 0 has no producer, even when an accepted slot names it as rd
	a_reg0_valid: assert property (@(posedge clk) disable iff (rst) valid_q[0]);

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input logic rst,
	input ooo_pkg::reg_idx_t [1:0] rd_addr,
	input ooo_pkg::commit_t [1:0] commit,
	output logic [1:0][ooo_pkg::word_w-1:0] rd_value
);

	logic [ooo_pkg::word_w-1:0] regs [ooo_pkg::num_regs];

	// ==========================================================================
	// read ports with commit bypass
	// ==========================================================================

	// a read in the same cycle as a commit sees the committed value, port 1
	// is checked first because it is the younger of the two
	always_comb begin
		for (int p = 0; p < 2; p++) begin
			if (rd_addr[p] == '0)
				rd_value[p] = '0;
			else if (commit[1].valid && commit[1].rd == rd_addr[p])
				rd_value[p] = commit[1].value;
			else if (commit[0].valid && commit[0].rd == rd_addr[p])
				rd_value[p] = commit[0].value;
			else
				rd_value[p] = regs[rd_addr[p]];
		end
	end

	// ==========================================================================
	// write ports
	// ==========================================================================

	// the architected state comes up as all zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < ooo_pkg::num_regs; r++)
				regs[r] <= '0;
		end else begin
			// later assignment wins, so port 1 takes a shared rd
			for (int k = 0; k < 2; k++) begin
				if (commit[k].valid && commit[k].rd != '0)
					regs[commit[k].rd] <= commit[k].value;
			end
		end
	end

endmodule

/* src/ooo_core.sv */
`timescale 1ns/1ps

module ooo_core #(
	parameter int NUM_LANES = 3,
	parameter int LANE_DEPTH = 2
) (
	input logic clk,
	input logic rst,
	input logic flush,
	input ooo_pkg::inst_t [1:0] in_slot,
	output logic in_ready,
	output ooo_pkg::commit_t [1:0] commit,
	output logic [ooo_pkg::num_regs-1:0] reg_ready
);

	ooo_pkg::reg_idx_t [1:0] rd_addr;
	logic [1:0][ooo_pkg::word_w-1:0] rd_value;
	ooo_pkg::tag_t [1:0] next_tag;
	ooo_pkg::rob_cnt_t rob_free;
	ooo_pkg::alloc_t [1:0] alloc;
	ooo_pkg::issue_t [NUM_LANES-1:0] issue;
	ooo_pkg::result_t [NUM_LANES-1:0] result;
	logic [NUM_LANES-1:0] credit_return;

	// ==========================================================================
	// front end
	// ==========================================================================

	dispatch_unit #(
		.NUM_LANES(NUM_LANES),
		.LANE_DEPTH(LANE_DEPTH)
	) dispatch_unit_inst (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.in_slot(in_slot),
		.reg_ready(reg_ready),
		.rd_value(rd_value),
		.next_tag(next_tag),
		.rob_free(rob_free),
		.credit_return(credit_return),
		.in_ready(in_ready),
		.rd_addr(rd_addr),
		.issue(issue),
		.alloc(alloc)
	);

	// lanes are interchangeable, dispatch fills them lowest first
	for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
		exec_lane #(
			.LANE_DEPTH(LANE_DEPTH)
		) exec_lane_inst (
			.clk(clk),
			.rst(rst),
			.flush(flush),
			.issue(issue[l]),
			.result(result[l]),
			.credit_return(credit_return[l])
		);
	end

	// ==========================================================================
	// in-order back end
	// ==========================================================================

	reorder_buffer #(
		.NUM_LANES(NUM_LANES)
	) reorder_buffer_inst (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.alloc(alloc),
		.result(result),
		.next_tag(next_tag),
		.rob_free(rob_free),
		.commit(commit)
	);

	// the tracker and the register file both see the same commit ports
	reg_valid_tracker reg_valid_tracker_inst (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.alloc(alloc),
		.commit(commit),
		.reg_ready(reg_ready)
	);

	reg_file reg_file_inst (
		.clk(clk),
		.rst(rst),
		.rd_addr(rd_addr),
		.commit(commit),
		.rd_value(rd_value)
	);

endmodule

/* sim/tb_ooo_core.sv */
`timescale 1ns/1ps

module tb_ooo_core;

	// one commit that the program-order model expects next
	typedef struct packed {
		ooo_pkg::tag_t tag;
		ooo_pkg::reg_idx_t rd;
		logic [31:0] value;
	} expect_t;

	// about 60 instructions at most a dozen cycles each, with a wide margin
	localparam int max_cycles = 4000;

	logic clk;
	logic rst;
	logic flush;
	ooo_pkg::inst_t [1:0] in_slot;
	logic in_ready;
	ooo_pkg::commit_t [1:0] commit;
	logic [15:0] reg_ready;

	logic [31:0] lfsr_state;
	logic [31:0] model_regs [16];
	logic [31:0] arch_regs [16];
	ooo_pkg::tag_t model_tag;
	expect_t expected [$];
	int cycles = 0;
	int checks;
	int errors;
	int tests;

	ooo_core ooo_core_inst (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.in_slot(in_slot),
		.in_ready(in_ready),
		.commit(commit),
		.reg_ready(reg_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// the run is cut off if the tests stop making progress
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: the tests did not finish within %0d cycles", max_cycles);
			$display("Regression failed");
			$finish;
		end
	end

	// ==========================================================================
	// helpers and reference model
	// ==========================================================================

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1, one step per bit handed out
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic ooo_pkg::inst_t make_inst(input ooo_pkg::op_e op,
			input ooo_pkg::reg_idx_t rd, input ooo_pkg::reg_idx_t rs, input logic [15:0] imm);
		ooo_pkg::inst_t s;
		s.valid = 1'b1;
		s.op = op;
		s.rd = rd;
		s.rs = rs;
		s.imm = imm;
		return s;
	endfunction

	function automatic ooo_pkg::inst_t random_inst();
		ooo_pkg::inst_t s;
		s.valid = 1'b1;
		s.op = ooo_pkg::op_e'(rand_bits(2));
		s.rd = ooo_pkg::reg_idx_t'(rand_bits(4));
		s.rs = ooo_pkg::reg_idx_t'(rand_bits(4));
		s.imm = 16'(rand_bits(16));
		return s;
	endfunction

	// the immediate is sign-extended before every opcode uses it
	function automatic logic [31:0] model_result(input ooo_pkg::op_e op, input logic [31:0] a,
			input logic [15:0] imm);
		logic [31:0] b;
		logic [63:0] prod;
		b = {{16{imm[15]}}, imm};
		prod = a * b;
		case (op)
			ooo_pkg::OP_ADD: return a + b;
			ooo_pkg::OP_XOR: return a ^ b;
			ooo_pkg::OP_SHL: return a << b[4:0];
			default: return prod[31:0];
		endcase
	endfunction

	// program-order execution of an accepted slot; register 0 stays zero
	task automatic model_accept(input ooo_pkg::inst_t s);
		expect_t e;
		// tags come from the buffer tail, one per accepted slot in order
		e.tag = model_tag;
		model_tag = model_tag + 1'b1;
		e.rd = s.rd;
		e.value = model_result(s.op, model_regs[s.rs], s.imm);
		if (s.rd != '0)
			model_regs[s.rd] = e.value;
		expected.push_back(e);
	endtask

	task automatic take_commit(input int p);
		expect_t e;
		if (expected.size() == 0) begin
			errors++;
			$display("an instruction committed at %0t that the model did not expect", $time);
		end else begin
			e = expected.pop_front();
			check_value($sformatf("commit[%0d].tag", p), 32'(commit[p].tag), 32'(e.tag));
			check_value($sformatf("commit[%0d].rd", p), 32'(commit[p].rd), 32'(e.rd));
			check_value($sformatf("commit[%0d].value", p), commit[p].value, e.value);
			if (e.rd != '0)
				arch_regs[e.rd] = e.value;
		end
	endtask

	// commits are sampled mid-cycle and take effect on the next rising edge;
	// port 0 is older, so it is matched first
	always @(negedge clk) begin
		if (!rst) begin
			if (commit[1].valid && !commit[0].valid) begin
				errors++;
				$display("commit port 1 was valid at %0t while port 0 was idle", $time);
			end
			for (int p = 0; p < 2; p++) begin
				if (commit[p].valid)
					take_commit(p);
			end
		end
	end

	// tasks start and end 1 ns after a rising edge;
	// in_ready is sampled mid-cycle, when the offered bundle has settled
	task automatic send_bundle(input ooo_pkg::inst_t s0, input ooo_pkg::inst_t s1);
		logic taken;
		taken = 1'b0;
		in_slot[0] = s0;
		in_slot[1] = s1;
		while (!taken) begin
			@(negedge clk);
			if (in_ready) begin
				model_accept(s0);
				if (s1.valid)
					model_accept(s1);
				taken = 1'b1;
			end
			@(posedge clk);
			#1;
		end
		in_slot = '0;
	endtask

	// once nothing is in flight every register must be valid again
	task automatic wait_drain();
		while (expected.size() != 0) begin
			@(posedge clk);
			#1;
		end
		@(negedge clk);
		check_value("reg_ready", 32'(reg_ready), 32'h0000_ffff);
		@(posedge clk);
		#1;
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err_before);
	endtask

	// ==========================================================================
	// directed tests
	// ==========================================================================

	task automatic check_reset_state();
		int err0;
		err0 = errors;
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_value("in_ready", 32'(in_ready), 32'd0);
		@(posedge clk);
		#1 rst = 1'b0;
		// the first cycle out of reset is still idle
		@(posedge clk);
		#1;
		@(negedge clk);
		check_value("in_ready", 32'(in_ready), 32'd1);
		check_value("reg_ready", 32'(reg_ready), 32'h0000_ffff);
		check_value("commit[0].valid", 32'(commit[0].valid), 32'd0);
		check_value("commit[1].valid", 32'(commit[1].valid), 32'd0);
		@(posedge clk);
		#1;
		report_test("reset", err0);
	endtask

	task automatic single_opcodes();
		int err0;
		err0 = errors;
		send_bundle(make_inst(ooo_pkg::OP_ADD, 4'd5, 4'd0, 16'h1234), '0);
		wait_drain();
		send_bundle(make_inst(ooo_pkg::OP_XOR, 4'd6, 4'd5, 16'h00ff), '0);
		wait_drain();
		send_bundle(make_inst(ooo_pkg::OP_SHL, 4'd7, 4'd5, 16'h0004), '0);
		wait_drain();
		send_bundle(make_inst(ooo_pkg::OP_MUL, 4'd8, 4'd5, 16'hfffd), '0);
		wait_drain();
		// a write to register 0 commits but leaves it zero
		send_bundle(make_inst(ooo_pkg::OP_ADD, 4'd0, 4'd5, 16'h0001), '0);
		wait_drain();
		send_bundle(make_inst(ooo_pkg::OP_ADD, 4'd9, 4'd0, 16'h0007), '0);
		wait_drain();
		report_test("single opcodes", err0);
	endtask

	task automatic dependent_chain();
		int err0;
		ooo_pkg::reg_idx_t prev;
		ooo_pkg::reg_idx_t rd;
		err0 = errors;
		prev = '0;
		// every instruction waits for the one before it through reg_ready
		for (int i = 0; i < 12; i++) begin
			rd = ooo_pkg::reg_idx_t'(i % 15 + 1);
			send_bundle(make_inst(ooo_pkg::op_e'(i % 4), rd, prev, 16'(i * 37 + 3)), '0);
			prev = rd;
		end
		wait_drain();
		report_test("dependent chain", err0);
	endtask

	task automatic mixed_bundles();
		int err0;
		ooo_pkg::inst_t s0;
		ooo_pkg::inst_t s1;
		err0 = errors;
		for (int b = 0; b < 20; b++) begin
			s0 = random_inst();
			s1 = random_inst();
			// a multiply ahead of an add lets the younger one finish first
			if (b % 4 == 0) begin
				s0.op = ooo_pkg::OP_MUL;
				s1.op = ooo_pkg::OP_ADD;
			end
			// the core never takes a bundle whose slot 1 reads slot 0's rd
			if (s0.rd != '0 && s1.rs == s0.rd)
				s1.rs = s1.rs + 1'b1;
			send_bundle(s0, s1);
		end
		wait_drain();
		report_test("mixed bundles", err0);
	endtask

	task automatic apply_flush();
		flush = 1'b1;
		@(negedge clk);
		check_value("in_ready", 32'(in_ready), 32'd0);
		@(posedge clk);
		#1;
		flush = 1'b0;
		// whatever had not committed is gone, the model restarts from the
		// committed state
		expected.delete();
		for (int r = 0; r < 16; r++)
			model_regs[r] = arch_regs[r];
		// the emptied buffer hands out tags from its first entry again
		model_tag = '0;
		@(negedge clk);
		check_value("reg_ready", 32'(reg_ready), 32'h0000_ffff);
		@(posedge clk);
		#1;
	endtask

	task automatic flush_during_mul();
		int err0;
		err0 = errors;
		send_bundle(make_inst(ooo_pkg::OP_MUL, 4'd10, 4'd5, 16'h0101),
			make_inst(ooo_pkg::OP_MUL, 4'd11, 4'd6, 16'h0033));
		send_bundle(make_inst(ooo_pkg::OP_MUL, 4'd12, 4'd7, 16'h7fff),
			make_inst(ooo_pkg::OP_ADD, 4'd13, 4'd8, 16'h0010));
		apply_flush();
		send_bundle(make_inst(ooo_pkg::OP_ADD, 4'd14, 4'd10, 16'h0001),
			make_inst(ooo_pkg::OP_XOR, 4'd15, 4'd12, 16'hf0f0));
		send_bundle(make_inst(ooo_pkg::OP_SHL, 4'd1, 4'd13, 16'h0001),
			make_inst(ooo_pkg::OP_MUL, 4'd2, 4'd11, 16'h0009));
		wait_drain();
		report_test("flush", err0);
	endtask

	// ==========================================================================
	// main sequence
	// ==========================================================================

	initial begin
		rst = 1'b1;
		flush = 1'b0;
		in_slot = '0;
		lfsr_state = 32'h137d5915;
		model_tag = '0;
		checks = 0;
		errors = 0;
		tests = 0;
		for (int r = 0; r < 16; r++) begin
			model_regs[r] = '0;
			arch_regs[r] = '0;
		end
		check_reset_state();
		single_opcodes();
		dependent_chain();
		mixed_bundles();
		flush_during_mul();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* build.f */
src/ooo_pkg.sv
src/dispatch_unit.sv
src/exec_lane.sv
src/reorder_buffer.sv
src/reg_valid_tracker.sv
src/reg_file.sv
src/ooo_core.sv
sim/tb_ooo_core.sv
